// ==== testbench/unary_row_golden.txt ====
// mode(0 load, 1 clear input) ifm w0 w1 w2 w3 psum0..psum3 expected0..expected3
// Column k uses wk, psumk and expectedk, all values in hex.
0 FF FF 00 80 10 00000 00100 01000 0ABCD 000FE 00100 0107F 0ABDC
0 00 FF C3 55 01 12345 00001 FFF00 00000 12345 00001 FFF00 00000
0 10 80 B4 FF 01 00010 00020 00030 00040 0001A 0002C 00040 00040
0 08 60 00 FF 02 00500 00600 00700 00800 00504 00600 00708 00801
1 77 FF 80 40 20 00111 00222 00333 00444 00111 00222 00333 00444
0 02 B9 B8 01 FF F0000 0F000 00F00 000F0 F0002 0F001 00F00 000F2
0 03 5D 5C FF 00 01234 05678 09ABC 0DEF0 01236 05679 09ABF 0DEF0
0 0C 33 FF C3 02 00020 00000 00100 00003 00025 0000C 0010A 00004
0 FF C3 01 FE 11 80000 00000 00042 00007 800C2 00000 0013F 00017

// ==== compile.f ====
+incdir+include
logic/usys_pkg.sv
logic/pe_link_if.sv
logic/bitstream_gen.sv
logic/bit_accumulator.sv
logic/pe_border.sv
logic/pe_inner.sv
logic/unary_row.sv
testbench/tb_unary_row.sv

// ==== Bender.yml ====
package:
  name: unary_row

sources:
  - include_dirs:
      - include
    files:
      - logic/usys_pkg.sv
      - logic/pe_link_if.sv
      - logic/bitstream_gen.sv
      - logic/bit_accumulator.sv
      - logic/pe_border.sv
      - logic/pe_inner.sv
      - logic/unary_row.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_unary_row.sv

// ==== testbench/tb_unary_row.sv ====
`timescale 1ns/1ps
`include "usys_config.svh"

module tb_unary_row;

    import usys_pkg::*;

    // Golden record layout with one word per field.
    localparam int REC_WORDS     = 14;
    localparam int NUM_REC       = 9;
    localparam int F_MODE        = 0;
    localparam int F_IFM         = 1;
    localparam int F_WGHT        = 2;
    localparam int F_PSUM        = 6;
    localparam int F_EXP         = 10;
    localparam int VALID_TIMEOUT = 400;

    logic     clk;
    logic     rst_n_i;
    logic     en_ifm_i;
    logic     clr_ifm_i;
    logic     en_wght_i;
    logic     clr_wght_i;
    logic     en_acc_i;
    logic     clr_acc_i;
    logic     mac_done_i;
    data_t    ifm_i;
    data_t    wght_i;
    sum_vec_t ofm_i;
    sum_vec_t ofm_o;
    logic     ofm_valid_o;

    logic [`USYS_SWIDTH-1:0] golden [0:REC_WORDS*NUM_REC-1];

    unary_row dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .en_ifm_i    (en_ifm_i),
        .clr_ifm_i   (clr_ifm_i),
        .en_wght_i   (en_wght_i),
        .clr_wght_i  (clr_wght_i),
        .en_acc_i    (en_acc_i),
        .clr_acc_i   (clr_acc_i),
        .mac_done_i  (mac_done_i),
        .ifm_i       (ifm_i),
        .wght_i      (wght_i),
        .ofm_i       (ofm_i),
        .ofm_o       (ofm_o),
        .ofm_valid_o (ofm_valid_o)
    );

    always #50 clk = ~clk;

    function automatic logic [`USYS_SWIDTH-1:0] field(input int rec, input int idx);
        return golden[rec*REC_WORDS + idx];
    endfunction

    // Galois step of x^8+x^6+x^5+x^4+1 computed bit by bit.
    function automatic data_t lfsr_next(input data_t s);
        logic  fb;
        data_t n;
        fb   = s[0];
        n[7] = fb;
        n[6] = s[7];
        n[5] = s[6] ^ fb;
        n[4] = s[5] ^ fb;
        n[3] = s[4] ^ fb;
        n[2] = s[3];
        n[1] = s[2];
        n[0] = s[1];
        return n;
    endfunction

    // Product bits of one window against the counter and the random source.
    function automatic int window_count(input data_t ifm, input data_t w);
        data_t state;
        data_t cnt;
        int    ones;
        int    n;
        state = LFSR_SEED;
        cnt   = '0;
        ones  = 0;
        for (n = 0; n < `USYS_WINDOW; n++) begin
            if ((ifm > cnt) && (w > state)) begin
                ones++;
            end
            state = lfsr_next(state);
            cnt   = cnt + 1'b1;
        end
        return ones;
    endfunction

    // Mode 1 clears the input so nothing is added.
    function automatic int model_count(input int rec, input int col);
        if (field(rec, F_MODE) != 0) begin
            return 0;
        end
        return window_count(data_t'(field(rec, F_IFM)), data_t'(field(rec, F_WGHT + col)));
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic compare_sum(input string name, input sum_t exp_val, input sum_t act_val);
        if (act_val !== exp_val) begin
            report_error($sformatf("Fail: %s expected 0x%05h actual 0x%05h",
                                   name, exp_val, act_val));
        end
    endtask

    task automatic compare_valid(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            report_error($sformatf("Fail: %s expected 0x%0h actual 0x%0h",
                                   name, exp_val, act_val));
        end
    endtask

    task automatic check_golden();
        int   rec;
        int   col;
        sum_t model;
        for (rec = 0; rec < NUM_REC; rec++) begin
            for (col = 0; col < `USYS_COLS; col++) begin
                model = sum_t'(field(rec, F_PSUM + col)) + sum_t'(model_count(rec, col));
                if (model !== sum_t'(field(rec, F_EXP + col))) begin
                    report_error($sformatf(
                        "Golden record %0d column %0d disagrees with the model.",
                        rec, col));
                end
            end
        end
    endtask

    task automatic pulse_clear_acc();
        @(posedge clk);
        clr_acc_i <= 1'b1;
        @(posedge clk);
        clr_acc_i <= 1'b0;
    endtask

    task automatic run_window(input int rec, input sum_vec_t psum, input bit back_to_back);
        int n;
        int p;
        int waited;
        bit seen;
        if (!back_to_back) begin
            pulse_clear_acc();
        end
        @(posedge clk);
        ifm_i <= data_t'(field(rec, F_IFM));
        if (field(rec, F_MODE) != 0) begin
            clr_ifm_i <= 1'b1;
        end else begin
            en_ifm_i <= 1'b1;
        end
        @(posedge clk);
        en_ifm_i  <= 1'b0;
        clr_ifm_i <= 1'b0;
        // Last column's weight goes first.
        for (p = 0; p < `USYS_COLS; p++) begin
            @(posedge clk);
            en_wght_i <= 1'b1;
            wght_i    <= data_t'(field(rec, F_WGHT + `USYS_COLS - 1 - p));
        end
        @(posedge clk);
        en_wght_i <= 1'b0;
        for (n = 0; n < `USYS_WINDOW; n++) begin
            @(posedge clk);
            en_acc_i <= 1'b1;
        end
        @(posedge clk);
        en_acc_i   <= 1'b0;
        mac_done_i <= 1'b1;
        ofm_i      <= psum;
        @(posedge clk);
        mac_done_i <= 1'b0;
        clr_acc_i  <= back_to_back;
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk);
            clr_acc_i <= 1'b0;
            waited++;
            if (ofm_valid_o === 1'b1) begin
                seen = 1'b1;
            end else if (waited >= VALID_TIMEOUT) begin
                report_error("Timed out waiting for ofm_valid_o after mac_done_i.");
            end
        end
        if (waited != `USYS_COLS) begin
            report_error($sformatf("ofm_valid_o rose %0d cycles after mac_done_i, not %0d.",
                                   waited, `USYS_COLS));
        end
    endtask

    // Sums at the valid pulse and again one cycle later while they hold.
    task automatic check_outputs(input sum_vec_t expected);
        int col;
        for (col = 0; col < `USYS_COLS; col++) begin
            compare_sum($sformatf("ofm_o[%0d]", col), expected[col], ofm_o[col]);
        end
        @(posedge clk);
        compare_valid("ofm_valid_o", 1'b0, ofm_valid_o);
        for (col = 0; col < `USYS_COLS; col++) begin
            compare_sum($sformatf("ofm_o[%0d]", col), expected[col], ofm_o[col]);
        end
    endtask

    initial begin
        sum_vec_t    psum;
        sum_vec_t    expected;
        logic [31:0] rng;
        int          rec;
        int          col;
        clk         = 1'b0;
        rst_n_i    <= 1'b0;
        en_ifm_i   <= 1'b0;
        clr_ifm_i  <= 1'b0;
        en_wght_i  <= 1'b0;
        clr_wght_i <= 1'b0;
        en_acc_i   <= 1'b0;
        clr_acc_i  <= 1'b0;
        mac_done_i <= 1'b0;
        ifm_i      <= '0;
        wght_i     <= '0;
        ofm_i      <= '0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        compare_valid("ofm_valid_o", 1'b0, ofm_valid_o);
        for (col = 0; col < `USYS_COLS; col++) begin
            compare_sum($sformatf("ofm_o[%0d]", col), '0, ofm_o[col]);
        end

        $readmemh("testbench/unary_row_golden.txt", golden);
        if (^golden[REC_WORDS*NUM_REC-1] === 1'bx) begin
            report_error("The golden file is missing or shorter than expected.");
        end
        check_golden();

        for (rec = 0; rec < NUM_REC; rec++) begin
            for (col = 0; col < `USYS_COLS; col++) begin
                psum[col]     = sum_t'(field(rec, F_PSUM + col));
                expected[col] = sum_t'(field(rec, F_EXP + col));
            end
            run_window(rec, psum, 1'b0);
            check_outputs(expected);
        end

        // Same records again back to back with random partial sums.
        rng = 32'h93bd_3007;
        pulse_clear_acc();
        for (rec = 0; rec < NUM_REC; rec++) begin
            for (col = 0; col < `USYS_COLS; col++) begin
                rng           = xorshift32(rng);
                psum[col]     = sum_t'(rng);
                expected[col] = psum[col] + sum_t'(model_count(rec, col));
            end
            run_window(rec, psum, 1'b1);
            check_outputs(expected);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== logic/unary_row.sv ====
`timescale 1ns/1ps
`include "usys_config.svh"

module unary_row (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               en_ifm_i,
    input  logic               clr_ifm_i,
    input  logic               en_wght_i,
    input  logic               clr_wght_i,
    input  logic               en_acc_i,
    input  logic               clr_acc_i,
    input  logic               mac_done_i,
    input  usys_pkg::data_t    ifm_i,
    input  usys_pkg::data_t    wght_i,
    input  usys_pkg::sum_vec_t ofm_i,
    output usys_pkg::sum_vec_t ofm_o,
    output logic               ofm_valid_o
);

    // Link k leaves column k.
    pe_link_if link [`USYS_COLS] ();

    pe_border u_border (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .en_ifm_i   (en_ifm_i),
        .clr_ifm_i  (clr_ifm_i),
        .en_wght_i  (en_wght_i),
        .clr_wght_i (clr_wght_i),
        .en_acc_i   (en_acc_i),
        .clr_acc_i  (clr_acc_i),
        .mac_done_i (mac_done_i),
        .ifm_i      (ifm_i),
        .wght_i     (wght_i),
        .ofm_i      (ofm_i[0]),
        .ofm_o      (ofm_o[0]),
        .link_o     (link[0])
    );

    for (genvar k = 1; k < `USYS_COLS; k++) begin : g_inner
        pe_inner u_inner (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .link_i  (link[k-1]),
            .ofm_i   (ofm_i[k]),
            .link_o  (link[k]),
            .ofm_o   (ofm_o[k])
        );
    end

    // Last column's mac_done, one hop on, so every sum is settled.
    assign ofm_valid_o = link[`USYS_COLS-1].mac_done;

endmodule

// ==== logic/pe_inner.sv ====
`timescale 1ns/1ps

module pe_inner (
    input  logic           clk,
    input  logic           rst_n_i,
    pe_link_if.rx          link_i,
    input  usys_pkg::sum_t ofm_i,
    pe_link_if.tx          link_o,
    output usys_pkg::sum_t ofm_o
);

    import usys_pkg::*;

    data_t wght_q;
    logic  wght_bit;
    logic  prod_bit;

    // Shifted weight from the left neighbour.
    always_ff @(posedge clk) begin
        if (link_i.clr_wght) begin
            wght_q <= '0;
        end else if (link_i.en_wght) begin
            wght_q <= link_i.wght;
        end
    end

    // Same random number as the border, one hop later.
    assign wght_bit = (wght_q > link_i.rand_w);
    assign prod_bit = link_i.ifm_bit & wght_bit;

    bit_accumulator u_acc (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .en_i       (link_i.en_acc),
        .clr_i      (link_i.clr_acc),
        .mac_done_i (link_i.mac_done),
        .prod_bit_i (prod_bit),
        .sum_i      (ofm_i),
        .sum_o      (ofm_o)
    );

    // Strobes for the next column.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            link_o.en_wght  <= 1'b0;
            link_o.clr_wght <= 1'b0;
            link_o.en_acc   <= 1'b0;
            link_o.clr_acc  <= 1'b0;
            link_o.mac_done <= 1'b0;
        end else begin
            link_o.en_wght  <= link_i.en_wght;
            link_o.clr_wght <= link_i.clr_wght;
            link_o.en_acc   <= link_i.en_acc;
            link_o.clr_acc  <= link_i.clr_acc;
            link_o.mac_done <= link_i.mac_done;
        end
    end

    // Payload hop.
    always_ff @(posedge clk) begin
        link_o.wght    <= wght_q;
        link_o.ifm_bit <= link_i.ifm_bit;
        link_o.rand_w  <= link_i.rand_w;
    end

endmodule

// ==== logic/pe_border.sv ====
`timescale 1ns/1ps

module pe_border (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            en_ifm_i,
    input  logic            clr_ifm_i,
    input  logic            en_wght_i,
    input  logic            clr_wght_i,
    input  logic            en_acc_i,
    input  logic            clr_acc_i,
    input  logic            mac_done_i,
    input  usys_pkg::data_t ifm_i,
    input  usys_pkg::data_t wght_i,
    input  usys_pkg::sum_t  ofm_i,
    output usys_pkg::sum_t  ofm_o,
    pe_link_if.tx           link_o
);

    import usys_pkg::*;

    data_t ifm_q;
    data_t wght_q;
    data_t rand_w;
    logic  ifm_bit;
    logic  prod_bit;

    // Input feature register.
    always_ff @(posedge clk) begin
        if (clr_ifm_i) begin
            ifm_q <= '0;
        end else if (en_ifm_i) begin
            ifm_q <= ifm_i;
        end
    end

    // Head of the weight shift chain.
    always_ff @(posedge clk) begin
        if (clr_wght_i) begin
            wght_q <= '0;
        end else if (en_wght_i) begin
            wght_q <= wght_i;
        end
    end

    bitstream_gen u_gen (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .en_i       (en_acc_i),
        .clr_i      (clr_acc_i),
        .ifm_i      (ifm_q),
        .wght_i     (wght_q),
        .ifm_bit_o  (ifm_bit),
        .rand_w_o   (rand_w),
        .prod_bit_o (prod_bit)
    );

    bit_accumulator u_acc (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .en_i       (en_acc_i),
        .clr_i      (clr_acc_i),
        .mac_done_i (mac_done_i),
        .prod_bit_i (prod_bit),
        .sum_i      (ofm_i),
        .sum_o      (ofm_o)
    );

    // Strobes for column one.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            link_o.en_wght  <= 1'b0;
            link_o.clr_wght <= 1'b0;
            link_o.en_acc   <= 1'b0;
            link_o.clr_acc  <= 1'b0;
            link_o.mac_done <= 1'b0;
        end else begin
            link_o.en_wght  <= en_wght_i;
            link_o.clr_wght <= clr_wght_i;
            link_o.en_acc   <= en_acc_i;
            link_o.clr_acc  <= clr_acc_i;
            link_o.mac_done <= mac_done_i;
        end
    end

    // Weight leaves one cycle behind its register, streams stay aligned with en_acc.
    always_ff @(posedge clk) begin
        link_o.wght    <= wght_q;
        link_o.ifm_bit <= ifm_bit;
        link_o.rand_w  <= rand_w;
    end

endmodule

// ==== logic/bit_accumulator.sv ====
`timescale 1ns/1ps
`include "usys_config.svh"

module bit_accumulator (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           en_i,
    input  logic           clr_i,
    input  logic           mac_done_i,
    input  logic           prod_bit_i,
    input  usys_pkg::sum_t sum_i,
    output usys_pkg::sum_t sum_o
);

    import usys_pkg::*;

    // One extra bit so a full window of ones fits.
    logic [`USYS_DWIDTH:0] cnt_q;

    // Ones counter over the window.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (clr_i) begin
            cnt_q <= '0;
        end else if (en_i) begin
            cnt_q <= cnt_q + prod_bit_i;
        end
    end

    // Partial sum added once per window.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sum_o <= '0;
        end else if (mac_done_i) begin
            sum_o <= sum_i + sum_t'(cnt_q);
        end
    end

endmodule

// ==== logic/bitstream_gen.sv ====
`timescale 1ns/1ps

module bitstream_gen (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            en_i,
    input  logic            clr_i,
    input  usys_pkg::data_t ifm_i,
    input  usys_pkg::data_t wght_i,
    output logic            ifm_bit_o,
    output usys_pkg::data_t rand_w_o,
    output logic            prod_bit_o
);

    import usys_pkg::*;

    // Galois feedback mask for x^8+x^6+x^5+x^4+1.
    localparam data_t LFSR_TAPS = data_t'(8'hB8);

    data_t cnt_q;
    data_t lfsr_q;
    logic  wght_bit;

    // Unary counter, one step per enable cycle.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (clr_i) begin
            cnt_q <= '0;
        end else if (en_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Right shift, taps applied when a one drops out.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lfsr_q <= LFSR_SEED;
        end else if (clr_i) begin
            lfsr_q <= LFSR_SEED;
        end else if (en_i) begin
            lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : '0);
        end
    end

    // Temporal code for the input.
    assign ifm_bit_o = (ifm_i > cnt_q);

    // Rate code for the weight.
    assign wght_bit = (wght_i > lfsr_q);

    assign rand_w_o = lfsr_q;

    // Product of the two streams.
    assign prod_bit_o = ifm_bit_o & wght_bit;

endmodule

// ==== logic/pe_link_if.sv ====
`timescale 1ns/1ps

interface pe_link_if;

    import usys_pkg::*;

    // Control strobes, one column late per hop.
    logic  en_wght;
    logic  clr_wght;
    logic  en_acc;
    logic  clr_acc;
    logic  mac_done;

    // Weight shifting along the row.
    data_t wght;

    // Shared streams from the border.
    logic  ifm_bit;
    data_t rand_w;

    modport tx (
        output en_wght, clr_wght, en_acc, clr_acc, mac_done,
        output wght, ifm_bit, rand_w
    );

    modport rx (
        input  en_wght, clr_wght, en_acc, clr_acc, mac_done,
        input  wght, ifm_bit, rand_w
    );

endinterface

// ==== logic/usys_pkg.sv ====
`include "usys_config.svh"

package usys_pkg;

    // Unsigned input or weight word.
    typedef logic [`USYS_DWIDTH-1:0] data_t;

    // Unsigned partial sum.
    typedef logic [`USYS_SWIDTH-1:0] sum_t;

    // One sum per column, column 0 at index 0.
    typedef sum_t [`USYS_COLS-1:0] sum_vec_t;

    // Start state of the random source.
    // Must be nonzero or the LFSR locks up.
    localparam data_t LFSR_SEED = data_t'(8'h01);

endpackage

// ==== include/usys_config.svh ====
`ifndef USYS_CONFIG_SVH
`define USYS_CONFIG_SVH

// Input and weight width.
`define USYS_DWIDTH 8

// Partial sum width.
`define USYS_SWIDTH 20

// Columns in one row.
`define USYS_COLS 4

// Enable cycles in one multiply window, one per counter value.
`define USYS_WINDOW (1 << `USYS_DWIDTH)

`endif
